// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and address width
`define XLEN 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// architectural integer registers
`define NUM_REGS 32

`endif

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011 // only csrrw / csrrs used
	} opcode_e;

	typedef enum logic [2:0] {
		type_r = 3'd0,
		type_i = 3'd1,
		type_s = 3'd2,
		type_b = 3'd3,
		type_u = 3'd4,
		type_j = 3'd5
	} inst_type_e;

	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_xor   = 4'd3,
		alu_or    = 4'd4,
		alu_srl   = 4'd5,
		alu_sra   = 4'd6,
		alu_sll   = 4'd7,
		alu_less  = 4'd8, // slt / slti
		alu_uless = 4'd9  // sltu / sltiu
	} alu_op_e;

	// machine-mode csrs implemented by the core
	typedef enum logic [11:0] {
		csr_mtvec    = 12'h305,
		csr_mscratch = 12'h340,
		csr_mepc     = 12'h341,
		csr_mcause   = 12'h342
	} csr_addr_e;

endpackage

// ==== rtl/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

	// one instruction after decode and register read
	typedef struct packed {
		rv_isa_pkg::opcode_e    opcode;
		rv_isa_pkg::inst_type_e inst_type;
		logic [2:0]             funct3;
		logic [6:0]             funct7;
		logic [4:0]             rd;
		logic                   rf_wen;    // rd write, already false for x0
		logic                   csr_en;    // csrrw or csrrs
		rv_isa_pkg::csr_addr_e  csr_addr;
		logic [`XLEN-1:0]       imm;       // sign extended
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       src1;
		logic [`XLEN-1:0]       src2;
	} decoded_t;

	// execute unit output towards write-back
	typedef struct packed {
		logic [`XLEN-1:0] val;         // alu result, link value or store address
		logic             jump_taken;
		logic [`XLEN-1:0] jump_target;
		logic [3:0]       wmask;       // unshifted byte mask
		logic [`XLEN-1:0] csr_wdata;
	} exu_result_t;

endpackage

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module regfile (
	input  logic             clk,
	input  logic             rst,
	input  logic [4:0]       raddr1,
	input  logic [4:0]       raddr2,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2,
	input  logic             wen,
	input  logic [4:0]       waddr,
	input  logic [`XLEN-1:0] wdata
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin // x0 stays hardwired
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// x0 must survive every write-back the core issues
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0)
		else $error("regfile: x0 holds a non-zero value");

endmodule

// ==== rtl/idu.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module idu (
	input  logic               [`XLEN-1:0] inst,
	input  logic               [`XLEN-1:0] pc,
	input  logic               [`XLEN-1:0] rdata1,
	input  logic               [`XLEN-1:0] rdata2,
	output logic               [4:0]       raddr1,
	output logic               [4:0]       raddr2,
	output core_pkg::decoded_t             dec
);

	import rv_isa_pkg::*;

	opcode_e          opcode;
	inst_type_e       inst_type;
	logic [2:0]       funct3;
	logic [4:0]       rd;
	logic             wr_class;  // opcode class that writes rd
	logic             csr_en;
	logic [`XLEN-1:0] imm;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rd     = inst[11:7];
	assign raddr1 = inst[19:15];
	assign raddr2 = inst[24:20];

	assign csr_en = (opcode == opc_system) && (funct3 == 3'b001 || funct3 == 3'b010);

	// format and write class per opcode
	always_comb begin
		inst_type = type_r;
		wr_class  = 1'b0;
		case (opcode)
			opc_lui, opc_auipc: begin
				inst_type = type_u;
				wr_class  = 1'b1;
			end
			opc_jal: begin
				inst_type = type_j;
				wr_class  = 1'b1;
			end
			opc_jalr, opc_op_imm: begin
				inst_type = type_i;
				wr_class  = 1'b1;
			end
			opc_branch: inst_type = type_b;
			opc_store:  inst_type = type_s;
			opc_op:     wr_class  = 1'b1;
			opc_system: begin
				inst_type = type_i;
				wr_class  = csr_en; // other system encodings are no-ops
			end
			default: ; // unknown opcode, nothing written
		endcase
	end

	always_comb begin
		case (inst_type)
			type_i:  imm = {{20{inst[31]}}, inst[31:20]};
			type_s:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			type_b:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			type_u:  imm = {inst[31:12], 12'b0};
			type_j:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default: imm = '0; // r-type has none
		endcase
	end

	assign dec = '{
		opcode:    opcode,
		inst_type: inst_type,
		funct3:    funct3,
		funct7:    inst[31:25],
		rd:        rd,
		rf_wen:    wr_class && (rd != 5'd0),
		csr_en:    csr_en,
		csr_addr:  csr_addr_e'(inst[31:20]),
		imm:       imm,
		pc:        pc,
		src1:      rdata1,
		src2:      rdata2
	};

endmodule

// ==== rtl/exu.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module exu (
	input  core_pkg::decoded_t    dec,
	input  logic [`XLEN-1:0]      csr_val,
	output core_pkg::exu_result_t res
);

	import rv_isa_pkg::*;

	logic [`XLEN-1:0] lop;
	logic [`XLEN-1:0] rop;
	alu_op_e          alu_op;
	logic [`XLEN-1:0] alu_val;
	logic             br_cond;
	logic             is_jalr;
	logic             jump_taken;
	logic [`XLEN-1:0] target_sum;
	logic [3:0]       wmask;
	logic [`XLEN-1:0] csr_wdata;

	// operand select
	always_comb begin
		case (dec.opcode)
			opc_lui: begin
				lop = '0;
				rop = dec.imm;
			end
			opc_auipc: begin
				lop = dec.pc;
				rop = dec.imm;
			end
			opc_jal, opc_jalr: begin // link value
				lop = dec.pc;
				rop = 32'd4;
			end
			opc_op_imm, opc_store: begin // store gives effective address
				lop = dec.src1;
				rop = dec.imm;
			end
			opc_op: begin
				lop = dec.src1;
				rop = dec.src2;
			end
			default: begin
				lop = '0;
				rop = '0;
			end
		endcase
	end

	always_comb begin
		alu_op = alu_add;
		if (dec.opcode == opc_op || dec.opcode == opc_op_imm) begin
			case (dec.funct3)
				3'b000: alu_op = (dec.inst_type == type_r && dec.funct7[5]) ? alu_sub : alu_add;
				3'b001: alu_op = alu_sll;
				3'b010: alu_op = alu_less;
				3'b011: alu_op = alu_uless;
				3'b100: alu_op = alu_xor;
				3'b101: alu_op = dec.funct7[5] ? alu_sra : alu_srl; // imm[10] for srai
				3'b110: alu_op = alu_or;
				default: alu_op = alu_and;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			alu_sub:   alu_val = lop - rop;
			alu_and:   alu_val = lop & rop;
			alu_xor:   alu_val = lop ^ rop;
			alu_or:    alu_val = lop | rop;
			alu_srl:   alu_val = lop >> rop[4:0];
			alu_sra:   alu_val = $signed(lop) >>> rop[4:0];
			alu_sll:   alu_val = lop << rop[4:0];
			alu_less:  alu_val = {31'b0, $signed(lop) < $signed(rop)};
			alu_uless: alu_val = {31'b0, lop < rop};
			default:   alu_val = lop + rop;
		endcase
	end

	// branch comparator, always on the register operands
	always_comb begin
		case (dec.funct3)
			3'b000:  br_cond = dec.src1 == dec.src2;
			3'b001:  br_cond = dec.src1 != dec.src2;
			3'b100:  br_cond = $signed(dec.src1) < $signed(dec.src2);
			3'b101:  br_cond = $signed(dec.src1) >= $signed(dec.src2);
			3'b110:  br_cond = dec.src1 < dec.src2;
			3'b111:  br_cond = dec.src1 >= dec.src2;
			default: br_cond = 1'b0;
		endcase
	end

	assign is_jalr    = dec.opcode == opc_jalr;
	assign jump_taken = (dec.inst_type == type_j) || is_jalr ||
	                    (dec.inst_type == type_b && br_cond);
	assign target_sum = (is_jalr ? dec.src1 : dec.pc) + dec.imm;

	always_comb begin
		case (dec.funct3[1:0])
			2'b00:   wmask = 4'h1; // sb
			2'b01:   wmask = 4'h3; // sh
			2'b10:   wmask = 4'hf; // sw
			default: wmask = 4'h0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b001:  csr_wdata = dec.src1;           // csrrw
			3'b010:  csr_wdata = dec.src1 | csr_val; // csrrs
			default: csr_wdata = '0;
		endcase
	end

	assign res = '{
		val:         alu_val,
		jump_taken:  jump_taken,
		jump_target: {target_sum[31:1], target_sum[0] & ~is_jalr},
		wmask:       wmask,
		csr_wdata:   csr_wdata
	};

	// format classification from idu must never make an alu op redirect fetch
	always_comb begin
		if (dec.opcode inside {opc_op, opc_op_imm, opc_lui, opc_auipc}) begin
			a_no_alu_jump: assert final (!res.jump_taken)
				else $error("exu: jump taken on an alu-class instruction");
		end
	end

endmodule

// ==== rtl/wbu.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module wbu (
	input  logic                  clk,
	input  logic                  rst,
	input  core_pkg::decoded_t    dec,
	input  core_pkg::exu_result_t res,
	output logic [`XLEN-1:0]      csr_val,
	output logic                  rf_wen,
	output logic [4:0]            rf_waddr,
	output logic [`XLEN-1:0]      rf_wdata,
	output logic [`XLEN-1:0]      pc,
	output logic                  dmem_wen,
	output logic [`XLEN-1:0]      dmem_addr,
	output logic [`XLEN-1:0]      dmem_wdata,
	output logic [3:0]            dmem_wmask,
	output logic                  retire
);

	import rv_isa_pkg::*;

	logic             run;  // low for the cycle right after reset
	logic [`XLEN-1:0] mscratch;
	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;
	logic [1:0]       lane;

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else if (run) begin
			pc <= res.jump_taken ? res.jump_target : pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mscratch <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mcause   <= '0;
		end else if (run && dec.csr_en) begin
			case (dec.csr_addr)
				csr_mscratch: mscratch <= res.csr_wdata;
				csr_mtvec:    mtvec    <= res.csr_wdata;
				csr_mepc:     mepc     <= res.csr_wdata;
				csr_mcause:   mcause   <= res.csr_wdata;
				default: ; // unimplemented csr, write dropped
			endcase
		end
	end

	always_comb begin
		case (dec.csr_addr)
			csr_mscratch: csr_val = mscratch;
			csr_mtvec:    csr_val = mtvec;
			csr_mepc:     csr_val = mepc;
			csr_mcause:   csr_val = mcause;
			default:      csr_val = '0;
		endcase
	end

	assign rf_wen   = run && dec.rf_wen;
	assign rf_waddr = dec.rd;
	assign rf_wdata = dec.csr_en ? csr_val : res.val; // csr ops return the old value

	assign lane       = res.val[1:0];
	assign dmem_wen   = run && (dec.opcode == opc_store);
	assign dmem_addr  = {res.val[31:2], 2'b00};
	assign dmem_wdata = dec.src2 << {lane, 3'b000};
	assign dmem_wmask = res.wmask << lane;
	assign retire     = run;

	// idu decode must keep stores and register writes apart
	a_store_no_rf: assert property (@(posedge clk) disable iff (rst)
		!(dmem_wen && rf_wen))
		else $error("wbu: store and register write in the same cycle");

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module cpu_top (
	input  logic             clk,
	input  logic             rst,
	output logic [`XLEN-1:0] imem_addr,
	input  logic [`XLEN-1:0] imem_rdata,
	output logic             dmem_wen,
	output logic [`XLEN-1:0] dmem_addr,
	output logic [`XLEN-1:0] dmem_wdata,
	output logic [3:0]       dmem_wmask,
	output logic             retire,
	output logic [`XLEN-1:0] retire_pc
);

	import core_pkg::*;

	decoded_t         dec;
	exu_result_t      res;
	logic [4:0]       raddr1;
	logic [4:0]       raddr2;
	logic [`XLEN-1:0] rdata1;
	logic [`XLEN-1:0] rdata2;
	logic             rf_wen;
	logic [4:0]       rf_waddr;
	logic [`XLEN-1:0] rf_wdata;
	logic [`XLEN-1:0] csr_val;
	logic [`XLEN-1:0] pc;

	regfile regfile_inst (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

	idu idu_inst (
		.inst   (imem_rdata),
		.pc     (pc),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.dec    (dec)
	);

	exu exu_inst (
		.dec     (dec),
		.csr_val (csr_val),
		.res     (res)
	);

	wbu wbu_inst (
		.clk        (clk),
		.rst        (rst),
		.dec        (dec),
		.res        (res),
		.csr_val    (csr_val),
		.rf_wen     (rf_wen),
		.rf_waddr   (rf_waddr),
		.rf_wdata   (rf_wdata),
		.pc         (pc),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.retire     (retire)
	);

	assign imem_addr = pc;
	assign retire_pc = pc; // single cycle, fetch pc is the retiring pc

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk; // 8 ns period

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/100ps
`include "core_macros.svh"

module cpu_tb;

	import rv_isa_pkg::*;

	logic             clk;
	logic             rst;
	logic [`XLEN-1:0] imem_addr;
	logic [`XLEN-1:0] imem_rdata;
	logic             dmem_wen;
	logic [`XLEN-1:0] dmem_addr;
	logic [`XLEN-1:0] dmem_wdata;
	logic [3:0]       dmem_wmask;
	logic             retire;
	logic [`XLEN-1:0] retire_pc;

	logic [31:0] imem [256];   // 1 KiB program space
	logic [31:0] m_regs [32];  // reference register copy
	logic [31:0] m_csr [4];    // mscratch, mtvec, mepc, mcause
	logic [31:0] m_pc;
	logic [31:0] final_pc;
	logic        checking;
	int          wp;           // next free instruction slot

	tb_clkgen clkgen_inst (.clk(clk));

	cpu_top cpu_top_inst (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.retire     (retire),
		.retire_pc  (retire_pc)
	);

	assign imem_rdata = imem[imem_addr[9:2]];

	task automatic stop_run;
		$display("SIMULATION FAILED");
		$fatal(1, "cpu_tb stopped on the first error");
	endtask

	task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		stop_run();
	endtask

	task automatic fail_plain(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		stop_run();
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	// ISA semantics of the ten integer operations
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			12'h340: return 0;
			12'h305: return 1;
			12'h341: return 2;
			default: return 3;
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic emit_sw(input logic [4:0] rs);
		emit(enc_s(12'h040, rs, 5'd0, 3'b010));
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800; // compensates the sign of the addi part
		emit({hi[31:12], rd, opc_lui});
		emit(enc_i(v[11:0], rd, 3'b000, rd, opc_op_imm));
	endtask

	task automatic build_program;
		logic [11:0] imm;
		logic [11:0] ca;
		logic [4:0]  shamt;
		for (int i = 0; i < 256; i++) begin
			imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, opc_op_imm); // addi x0 nop tagged by index
		end
		wp = 0;
		for (int r = 1; r <= 4; r++) begin
			load_const(5'(r), $urandom());
		end
		for (int f = 0; f < 8; f++) begin
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd5, opc_op));
			emit_sw(5);
			if (f == 0 || f == 5) begin // sub, sra
				emit(enc_r(7'h20, 5'd2, 5'd1, 3'(f), 5'd5, opc_op));
				emit_sw(5);
			end
			shamt = 5'($urandom());
			imm   = (f == 1 || f == 5) ? {7'h00, shamt} : 12'($urandom());
			emit(enc_i(imm, 5'd1, 3'(f), 5'd5, opc_op_imm));
			emit_sw(5);
			if (f == 5) begin // srai
				emit(enc_i({7'h20, shamt}, 5'd1, 3'(f), 5'd5, opc_op_imm));
				emit_sw(5);
			end
		end
		// each branch on equal and on swapped operands, skipping one addi when taken
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3) continue;
			emit(enc_b(13'd8, 5'd1, 5'd1, 3'(f)));
			emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, opc_op_imm));
			emit(enc_b(13'd8, 5'd2, 5'd1, 3'(f)));
			emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, opc_op_imm));
			emit(enc_b(13'd8, 5'd1, 5'd2, 3'(f)));
			emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, opc_op_imm));
		end
		emit_sw(6);
		emit(enc_j(21'd8, 5'd7));
		emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, opc_op_imm));
		emit_sw(7);
		emit({20'd0, 5'd8, opc_auipc});
		emit(enc_i(12'd13, 5'd8, 3'b000, 5'd9, opc_jalr)); // odd offset, bit 0 dropped
		emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, opc_op_imm));
		emit_sw(9);
		emit_sw(6);
		for (int off = 0; off < 4; off++) begin
			emit(enc_s(12'h100 + 12'(off), 5'd2, 5'd0, 3'b000)); // sb
			if (off % 2 == 0) begin
				emit(enc_s(12'h100 + 12'(off), 5'd1, 5'd0, 3'b001)); // sh
			end
		end
		for (int i = 0; i < 4; i++) begin
			case (i)
				0: ca = csr_mscratch;
				1: ca = csr_mtvec;
				2: ca = csr_mepc;
				default: ca = csr_mcause;
			endcase
			emit(enc_i(ca, 5'd3, 3'b001, 5'd10, opc_system)); // csrrw
			emit(enc_i(ca, 5'd4, 3'b010, 5'd11, opc_system)); // csrrs
			emit(enc_i(ca, 5'd0, 3'b010, 5'd12, opc_system)); // plain read back
			emit_sw(10);
			emit_sw(11);
			emit_sw(12);
		end
		for (int r = 1; r <= 12; r++) begin
			emit_sw(5'(r));
		end
		final_pc = 32'(wp * 4);
		emit(enc_j(21'd0, 5'd0)); // self-loop
	endtask

	// executes the instruction at m_pc and checks the store port of this cycle
	task automatic model_step;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] rd_val;
		logic [31:0] npc;
		logic [31:0] addr;
		logic [31:0] exp_data;
		logic [3:0]  mask;
		logic [2:0]  f3;
		logic        wr;
		int          slot;
		ins    = imem[m_pc[9:2]];
		f3     = ins[14:12];
		a      = m_regs[ins[19:15]];
		b      = m_regs[ins[24:20]];
		imm_i  = {{20{ins[31]}}, ins[31:20]};
		imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u  = {ins[31:12], 12'b0};
		imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		npc    = m_pc + 32'd4;
		rd_val = '0;
		wr     = 1'b0;
		case (ins[6:0])
			opc_lui: begin
				rd_val = imm_u;
				wr     = 1'b1;
			end
			opc_auipc: begin
				rd_val = m_pc + imm_u;
				wr     = 1'b1;
			end
			opc_jal: begin
				rd_val = m_pc + 32'd4;
				wr     = 1'b1;
				npc    = m_pc + imm_j;
			end
			opc_jalr: begin
				rd_val = m_pc + 32'd4;
				wr     = 1'b1;
				npc    = (a + imm_i) & ~32'd1;
			end
			opc_branch: begin
				if (branch_taken(f3, a, b)) npc = m_pc + imm_b;
			end
			opc_op_imm: begin
				rd_val = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
				wr     = 1'b1;
			end
			opc_op: begin
				rd_val = alu_ref(f3, ins[30], a, b);
				wr     = 1'b1;
			end
			opc_system: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					slot        = csr_slot(ins[31:20]);
					rd_val      = m_csr[slot];
					wr          = 1'b1;
					m_csr[slot] = (f3 == 3'b001) ? a : (a | m_csr[slot]);
				end
			end
			default: ;
		endcase
		if (ins[6:0] == opc_store) begin
			addr     = a + imm_s;
			mask     = (f3 == 3'b000) ? 4'h1 : (f3 == 3'b001) ? 4'h3 : 4'hf;
			mask     = mask << addr[1:0];
			exp_data = b << {addr[1:0], 3'b000};
			assert (dmem_wen) else fail_plain("no store strobe for a store instruction");
			assert (dmem_addr == {addr[31:2], 2'b00})
				else fail_value("dmem_addr", dmem_addr, {addr[31:2], 2'b00});
			assert (dmem_wmask == mask) else fail_value("dmem_wmask", 32'(dmem_wmask), 32'(mask));
			assert (dmem_wdata == exp_data) else fail_value("dmem_wdata", dmem_wdata, exp_data);
		end else begin
			assert (!dmem_wen) else fail_plain("store strobe on a non-store instruction");
		end
		if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = rd_val;
		m_pc = npc;
	endtask

	always @(negedge clk) begin
		if (checking) begin
			a_retire: assert (retire) else fail_plain("retire dropped while the core was running");
			a_pc: assert (retire_pc == m_pc) else fail_value("retire_pc", retire_pc, m_pc);
			a_fetch: assert (imem_addr == m_pc) else fail_value("imem_addr", imem_addr, m_pc);
			model_step();
		end
	end

	initial begin
		int cycles;
		void'($urandom(32'ha7a8));
		checking = 1'b0;
		m_pc     = `RESET_PC;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < 4; i++) begin
			m_csr[i] = '0;
		end
		build_program();
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk); // first cycle out of reset, nothing retires yet
		a_reset_pc: assert (retire_pc == `RESET_PC)
			else fail_value("retire_pc after reset", retire_pc, `RESET_PC);
		a_reset_idle: assert (!dmem_wen && !retire)
			else fail_plain("store or retire active in the first cycle after reset");
		checking <= 1'b1;
		cycles = 0;
		while (retire_pc !== final_pc && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (retire_pc === final_pc) begin
			repeat (4) @(negedge clk); // self-loop has to hold its pc
			@(posedge clk);
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_plain("timeout waiting for the final self-loop to retire");
		end
	end

endmodule

// ==== sim.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/regfile.sv
rtl/idu.sv
rtl/exu.sv
rtl/wbu.sv
rtl/cpu_top.sv
sim/tb_clkgen.sv
sim/cpu_tb.sv
